// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    // --------------------
    // core-side encodings
    // --------------------

    // access size, coded like the core's 2-bit mask
    typedef enum logic [1:0] {
        MASK_NONE = 2'b00,
        MASK_BYTE = 2'b01,
        MASK_HALF = 2'b10,
        MASK_WORD = 2'b11
    } lsu_size_e;

    // bus master channel states
    typedef enum logic [1:0] {
        BUS_IDLE = 2'd0,
        BUS_ADDR = 2'd1,
        BUS_DATA = 2'd2,
        BUS_RESP = 2'd3
    } bus_state_e;

    // --------------------
    // bus encodings
    // --------------------

    // AXI size codes, bytes per beat as a power of two
    localparam logic [2:0] SIZE_BYTE = 3'd0;
    localparam logic [2:0] SIZE_HALF = 3'd1;
    localparam logic [2:0] SIZE_WORD = 3'd2;

    // address map
    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [31:0] CLINT_END  = 32'h0200_ffff;
    localparam logic [31:0] SRAM_BASE  = 32'h8000_0000;

endpackage

// ==== verilog/lsu_store_align.sv ====
`timescale 1ns/1ns

module lsu_store_align (
    input  logic [31:0] waddr,
    input  logic [31:0] wdata,
    input  logic [1:0]  wmask,
    output logic [31:0] bus_wdata,
    output logic [3:0]  wstrb,
    output logic [2:0]  wsize
);

    import lsu_pkg::*;

    // byte offset within the word
    logic [1:0] offset;

    assign offset = waddr[1:0];

    // move the data up to its byte lane
    assign bus_wdata = wdata << {offset, 3'b000};

    // strobes and bus size by access width
    always_comb begin
        case (lsu_size_e'(wmask))
            MASK_BYTE: begin
                wstrb = 4'b0001 << offset;
                wsize = SIZE_BYTE;
            end
            MASK_HALF: begin
                wstrb = offset[1] ? 4'b1100 : 4'b0011;
                wsize = SIZE_HALF;
            end
            MASK_WORD: begin
                wstrb = 4'b1111;
                wsize = SIZE_WORD;
            end
            default: begin
                // nothing to write
                wstrb = 4'b0000;
                wsize = SIZE_BYTE;
            end
        endcase
    end

endmodule

// ==== verilog/lsu_bus_master.sv ====
`timescale 1ns/1ns

module lsu_bus_master (
    input  logic        clock,
    input  logic        reset,
    // core read request
    input  logic        rvalid_in,
    input  logic [31:0] raddr,
    input  logic [7:0]  rlen,
    input  logic        burst,
    input  logic [1:0]  rmask,
    // core write request, already aligned
    input  logic        wvalid_in,
    input  logic [31:0] waddr,
    input  logic [2:0]  wsize,
    input  logic [31:0] bus_wdata,
    input  logic [3:0]  wstrb,
    output logic        rdone,
    output logic [31:0] rword,
    output logic        wdone,
    // sram bus
    output logic [31:0] sram_araddr,
    output logic [7:0]  sram_arlen,
    output logic [2:0]  sram_arsize,
    output logic [1:0]  sram_arburst,
    output logic        sram_arvalid,
    input  logic        sram_arready,
    input  logic [31:0] sram_rdata,
    input  logic        sram_rvalid,
    input  logic        sram_rlast,
    output logic [31:0] sram_awaddr,
    output logic [2:0]  sram_awsize,
    output logic        sram_awvalid,
    input  logic        sram_awready,
    output logic [31:0] sram_wdata,
    output logic [3:0]  sram_wstrb,
    output logic        sram_wlast,
    output logic        sram_wvalid,
    input  logic        sram_wready,
    input  logic        sram_bvalid,
    // clint bus
    output logic [31:0] clint_araddr,
    output logic        clint_arvalid,
    input  logic        clint_arready,
    input  logic [31:0] clint_rdata,
    input  logic        clint_rvalid
);

    import lsu_pkg::*;

    bus_state_e rd_state, wr_state;
    logic        arvalid, arready, rvalid, rlast, rready, rd_end;
    logic        awvalid, wvalid, bready, aw_done, w_done, aw_ok, w_ok;
    logic        is_clint;
    logic [7:0]  arlen, rcount;

    // master always accepts data and responses
    assign rready = 1'b1;
    assign bready = 1'b1;

    // --------------------
    // read side
    // --------------------

    assign is_clint = (raddr >= CLINT_BASE) && (raddr <= CLINT_END);
    assign arlen    = burst ? rlen : 8'd0;
    assign arvalid  = (rd_state == BUS_ADDR);

    // steer the request, mux the answer back
    assign sram_arvalid  = arvalid & ~is_clint;
    assign clint_arvalid = arvalid & is_clint;
    assign arready       = is_clint ? clint_arready : sram_arready;
    assign rvalid        = is_clint ? clint_rvalid : sram_rvalid;
    assign rlast         = is_clint ? 1'b1 : sram_rlast;
    assign rword         = is_clint ? clint_rdata : sram_rdata;

    assign sram_araddr  = raddr;
    assign clint_araddr = raddr;
    assign sram_arlen   = arlen;
    assign sram_arburst = {1'b0, burst};

    always_comb begin
        case (lsu_size_e'(rmask))
            MASK_HALF: sram_arsize = SIZE_HALF;
            MASK_WORD: sram_arsize = SIZE_WORD;
            default:   sram_arsize = SIZE_BYTE;
        endcase
    end

    assign rdone  = rvalid & rready & (rd_state == BUS_DATA);
    assign rd_end = (rcount == arlen) | rlast;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_state <= BUS_IDLE;
            rcount   <= 8'd0;
        end else begin
            case (rd_state)
                BUS_IDLE: if (rvalid_in) rd_state <= BUS_ADDR;
                BUS_ADDR: if (arready) rd_state <= BUS_DATA;
                default:  if (rdone && rd_end) rd_state <= BUS_IDLE;
            endcase
            // beat counter
            if (rdone) begin
                rcount <= rd_end ? 8'd0 : rcount + 8'd1;
            end
        end
    end

    // --------------------
    // write side
    // --------------------

    assign awvalid = (wr_state == BUS_ADDR) & ~aw_done;
    assign wvalid  = (wr_state == BUS_ADDR) & ~w_done;
    assign aw_ok   = aw_done | (awvalid & sram_awready);
    assign w_ok    = w_done | (wvalid & sram_wready);

    assign sram_awvalid = awvalid;
    assign sram_awaddr  = waddr;
    assign sram_awsize  = wsize;
    assign sram_wvalid  = wvalid;
    // single-beat writes only
    assign sram_wlast   = wvalid;
    assign sram_wdata   = bus_wdata;
    assign sram_wstrb   = wstrb;

    assign wdone = sram_bvalid & bready & (wr_state == BUS_RESP);

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_state <= BUS_IDLE;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            case (wr_state)
                BUS_IDLE: if (wvalid_in) wr_state <= BUS_ADDR;
                BUS_ADDR: begin
                    // address and data may complete in either order
                    if (aw_ok && w_ok) begin
                        wr_state <= BUS_RESP;
                        aw_done  <= 1'b0;
                        w_done   <= 1'b0;
                    end else begin
                        aw_done <= aw_ok;
                        w_done  <= w_ok;
                    end
                end
                default: if (wdone) wr_state <= BUS_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/lsu_load_extend.sv ====
`timescale 1ns/1ns

module lsu_load_extend (
    input  logic [1:0]  raddr,
    input  logic [1:0]  rmask,
    input  logic        rsign,
    input  logic [31:0] rword,
    output logic [31:0] rdata
);

    import lsu_pkg::*;

    logic [31:0] shifted;
    logic        fill;

    // bring the addressed lane down to bit 0
    assign shifted = rword >> {raddr, 3'b000};

    // extend by size and sign
    always_comb begin
        fill = 1'b0;
        case (lsu_size_e'(rmask))
            MASK_BYTE: begin
                fill  = shifted[7] & rsign;
                rdata = {{24{fill}}, shifted[7:0]};
            end
            MASK_HALF: begin
                fill  = shifted[15] & rsign;
                rdata = {{16{fill}}, shifted[15:0]};
            end
            MASK_WORD: begin
                rdata = shifted;
            end
            default: begin
                rdata = 32'd0;
            end
        endcase
    end

endmodule

// ==== verilog/lsu_sram.sv ====
`timescale 1ns/1ns

module lsu_sram #(
    parameter int sram_words = 1024
) (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic        rlast,
    input  logic [31:0] awaddr,
    input  logic [2:0]  awsize,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid
);

    import lsu_pkg::*;

    localparam int index_bits = $clog2(sram_words);
    localparam logic [1:0] burst_incr = 2'b01;

    logic [31:0] mem [sram_words];
    logic [31:0] rd_addr, aw_addr_q, wr_addr;
    logic [2:0]  rd_size, aw_size_q, wr_size;
    logic [1:0]  rd_burst;
    logic [7:0]  rd_left;
    logic [3:0]  lanes, wr_strb;
    logic        accept, beat_next;

    function automatic logic [index_bits-1:0] word_index(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - SRAM_BASE;
        return offset[index_bits+1:2];
    endfunction

    function automatic logic [31:0] next_addr(input logic [31:0] addr,
                                              input logic [2:0] size,
                                              input logic [1:0] kind);
        return (kind == burst_incr) ? addr + (32'd1 << size) : addr;
    endfunction

    // no back-pressure on any channel
    assign arready = 1'b1;
    assign awready = 1'b1;
    assign wready  = 1'b1;

    // --------------------
    // read bursts
    // --------------------

    assign accept    = arvalid & arready;
    assign beat_next = rvalid & ~rlast;

    always_ff @(posedge clock) begin
        if (reset) begin
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rd_left <= 8'd0;
        end else if (accept) begin
            rvalid  <= 1'b1;
            rlast   <= (arlen == 8'd0);
            rd_left <= arlen;
        end else if (beat_next) begin
            rlast   <= (rd_left == 8'd1);
            rd_left <= rd_left - 8'd1;
        end else if (rvalid) begin
            // last beat has gone out
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rdata    <= mem[word_index(araddr)];
            rd_addr  <= next_addr(araddr, arsize, arburst);
            rd_size  <= arsize;
            rd_burst <= arburst;
        end else if (beat_next) begin
            rdata   <= mem[word_index(rd_addr)];
            rd_addr <= next_addr(rd_addr, rd_size, rd_burst);
        end
    end

    // --------------------
    // strobed writes
    // --------------------

    // address may come with the data or ahead of it
    assign wr_addr = awvalid ? awaddr : aw_addr_q;
    assign wr_size = awvalid ? awsize : aw_size_q;

    // narrow transfers only touch lanes inside their size
    always_comb begin
        case (wr_size)
            SIZE_BYTE: lanes = 4'b0001 << wr_addr[1:0];
            SIZE_HALF: lanes = wr_addr[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: lanes = 4'b1111;
            default:   lanes = 4'b1111;
        endcase
    end

    assign wr_strb = wstrb & lanes;

    always_ff @(posedge clock) begin
        if (awvalid) begin
            aw_addr_q <= awaddr;
            aw_size_q <= awsize;
        end
        if (wvalid) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) mem[word_index(wr_addr)][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) bvalid <= 1'b0;
        else bvalid <= wvalid & wready & wlast;
    end

endmodule

// ==== verilog/lsu_clint.sv ====
`timescale 1ns/1ns

module lsu_clint (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid
);

    // free-running cycle count
    logic [63:0] mtime;
    logic [31:0] half_sel;

    // read only, always ready
    assign arready = 1'b1;

    // bit 2 picks the upper word
    assign half_sel = araddr[2] ? mtime[63:32] : mtime[31:0];

    // --------------------
    // counter
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) mtime <= 64'd0;
        else mtime <= mtime + 64'd1;
    end

    // --------------------
    // read port
    // --------------------

    // one-cycle response, single beat
    always_ff @(posedge clock) begin
        if (reset) rvalid <= 1'b0;
        else rvalid <= arvalid & arready;
    end

    always_ff @(posedge clock) begin
        if (arvalid) begin
            rdata <= half_sel;
        end
    end

endmodule

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top #(
    parameter int sram_words = 1024
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        rvalid_in,
    input  logic [31:0] raddr,
    input  logic [7:0]  rlen,
    input  logic        burst,
    input  logic        rsign,
    input  logic [1:0]  rmask,
    input  logic        wvalid_in,
    input  logic [31:0] waddr,
    input  logic [31:0] wdata,
    input  logic [1:0]  wmask,
    output logic        rdone,
    output logic [31:0] rdata,
    output logic        wdone
);

    // store stage to master
    logic [31:0] bus_wdata, rword;
    logic [3:0]  wstrb;
    logic [2:0]  wsize;

    // sram bus
    logic [31:0] sram_araddr, sram_rdata, sram_awaddr, sram_wdata;
    logic [7:0]  sram_arlen;
    logic [2:0]  sram_arsize, sram_awsize;
    logic [1:0]  sram_arburst;
    logic [3:0]  sram_wstrb;
    logic        sram_arvalid, sram_arready, sram_rvalid, sram_rlast;
    logic        sram_awvalid, sram_awready, sram_wvalid, sram_wready;
    logic        sram_wlast, sram_bvalid;

    // clint bus
    logic [31:0] clint_araddr, clint_rdata;
    logic        clint_arvalid, clint_arready, clint_rvalid;

    lsu_store_align u_store (.waddr(waddr), .wdata(wdata), .wmask(wmask),
                             .bus_wdata(bus_wdata), .wstrb(wstrb), .wsize(wsize));

    lsu_bus_master u_master (.*);

    lsu_load_extend u_load (.raddr(raddr[1:0]), .rmask(rmask), .rsign(rsign),
                            .rword(rword), .rdata(rdata));

    lsu_sram #(.sram_words(sram_words)) u_sram (
        .clock(clock), .reset(reset),
        .araddr(sram_araddr), .arlen(sram_arlen), .arsize(sram_arsize),
        .arburst(sram_arburst), .arvalid(sram_arvalid), .arready(sram_arready),
        .rdata(sram_rdata), .rvalid(sram_rvalid), .rlast(sram_rlast),
        .awaddr(sram_awaddr), .awsize(sram_awsize), .awvalid(sram_awvalid),
        .awready(sram_awready), .wdata(sram_wdata), .wstrb(sram_wstrb),
        .wlast(sram_wlast), .wvalid(sram_wvalid), .wready(sram_wready),
        .bvalid(sram_bvalid)
    );

    lsu_clint u_clint (
        .clock(clock), .reset(reset),
        .araddr(clint_araddr), .arvalid(clint_arvalid), .arready(clint_arready),
        .rdata(clint_rdata), .rvalid(clint_rvalid)
    );

endmodule

// ==== sim/lsu_checker.sv ====
`timescale 1ns/1ns

module lsu_checker (
    input logic                clock,
    input logic                reset,
    input lsu_pkg::bus_state_e rd_state,
    input logic                rdone,
    input logic                wdone,
    input logic                sram_arvalid,
    input logic                sram_arready,
    input logic                clint_arvalid,
    input logic                clint_arready,
    input logic                sram_rvalid,
    input logic                clint_rvalid,
    input logic                sram_awvalid,
    input logic                sram_awready,
    input logic                sram_wvalid,
    input logic                sram_wlast
);

    import lsu_pkg::*;

    // failure count, visible to the testbench
    int fail_count;

    initial fail_count = 0;

    // --------------------
    // valid hold
    // --------------------

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        ((sram_arvalid && !sram_arready) || (clint_arvalid && !clint_arready))
        |=> (sram_arvalid || clint_arvalid))
    else begin
        fail_count++;
        $error("arvalid dropped before arready was seen");
    end

    aw_hold: assert property (@(posedge clock) disable iff (reset)
        (sram_awvalid && !sram_awready) |=> sram_awvalid)
    else begin
        fail_count++;
        $error("awvalid dropped before awready was seen");
    end

    // --------------------
    // read state and reset
    // --------------------

    // a target beat, which rdone passes on, only comes while a read is open
    rbeat_busy: assert property (@(posedge clock) disable iff (reset)
        (sram_rvalid || clint_rvalid) |-> (rd_state == BUS_DATA))
    else begin
        fail_count++;
        $error("a read beat arrived while the read side is idle");
    end

    // everything quiet right after a reset cycle
    reset_quiet: assert property (@(posedge clock)
        reset |=> !(sram_arvalid || clint_arvalid || sram_awvalid || sram_wvalid
                    || sram_wlast || rdone || wdone))
    else begin
        fail_count++;
        $error("a valid or done signal is high after reset");
    end

endmodule

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb;

    import lsu_pkg::*;

    localparam int model_words = 64;
    // word pairs, narrow store pairs, narrow loads, bursts, clint, reads with a second start
    localparam int total_requests = 128 + 64 + 32 + 16 + 3 + 8;
    localparam int timeout_cycles = total_requests * 20 + 8;

    logic        clock, reset;
    logic        rvalid_in, burst, rsign, wvalid_in;
    logic [31:0] raddr, waddr, wdata;
    logic [7:0]  rlen;
    logic [1:0]  rmask, wmask;
    logic        rdone, wdone;
    logic [31:0] rdata;

    integer      seed;
    int          check_count, error_count;
    logic [31:0] model_mem [model_words];
    logic [31:0] beat_q [$];

    lsu_top #(.sram_words(1024)) uut (.*);

    bind lsu_bus_master lsu_checker u_checker (
        .clock(clock), .reset(reset), .rd_state(rd_state), .rdone(rdone), .wdone(wdone),
        .sram_arvalid(sram_arvalid), .sram_arready(sram_arready),
        .clint_arvalid(clint_arvalid), .clint_arready(clint_arready),
        .sram_rvalid(sram_rvalid), .clint_rvalid(clint_rvalid),
        .sram_awvalid(sram_awvalid), .sram_awready(sram_awready),
        .sram_wvalid(sram_wvalid), .sram_wlast(sram_wlast)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clock);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    // --------------------
    // checks and model
    // --------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        check_count++;
        assert (got === expected) else begin
            $display("FAILED %s expected %h got %h", name, expected, got);
            error_count++;
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("error: %s", what);
            error_count++;
        end
    endtask

    task automatic match_beat(input int k, input logic [31:0] expected);
        if (k < beat_q.size()) check_value("rdata", expected, beat_q[k]);
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] sram_addr(input int idx, input int off);
        return SRAM_BASE + 32'(idx * 4 + off);
    endfunction

    // data moves up to its lane and the strobes pick the lanes written
    function automatic void update_model(input int idx, input logic [1:0] off,
                                         input logic [31:0] data, input lsu_size_e mask);
        logic [31:0] lanes;
        logic [3:0]  strb;
        lanes = data << {off, 3'b000};
        case (mask)
            MASK_BYTE: strb = 4'b0001 << off;
            MASK_HALF: strb = off[1] ? 4'b1100 : 4'b0011;
            MASK_WORD: strb = 4'b1111;
            default:   strb = 4'b0000;
        endcase
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) model_mem[idx][8*i +: 8] = lanes[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] extend_lane(input logic [31:0] word, input logic [1:0] off,
                                                input lsu_size_e mask, input logic sign);
        logic [31:0] lane;
        lane = word >> {off, 3'b000};
        case (mask)
            MASK_BYTE: return {{24{sign & lane[7]}}, lane[7:0]};
            MASK_HALF: return {{16{sign & lane[15]}}, lane[15:0]};
            MASK_WORD: return lane;
            default:   return 32'd0;
        endcase
    endfunction

    // --------------------
    // core-side requests
    // --------------------

    task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
                               input lsu_size_e mask);
        int   n;
        logic seen;
        @(posedge clock);
        #1;
        waddr     = addr;
        wdata     = data;
        wmask     = mask;
        wvalid_in = 1'b1;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 8) begin
            @(posedge clock);
            #1;
            n++;
            wvalid_in = 1'b0;
            if (wdone) begin
                seen = 1'b1;
                check_value("wdone_cycle", 32'd2, n);
            end
        end
        confirm(seen, "no wdone within 8 cycles of the write start");
    endtask

    // cycle n is sampled 1 ns after edge n; the start pulse sits in cycle 0
    task automatic issue_read(input logic [31:0] addr, input lsu_size_e mask, input logic sign,
                              input logic [7:0] len, input logic poke);
        int n;
        int quiet;
        int beats_expected;
        beat_q.delete();
        beats_expected = {24'd0, len} + 1;
        @(posedge clock);
        #1;
        raddr     = addr;
        rmask     = mask;
        rsign     = sign;
        rlen      = len;
        burst     = (len != 8'd0);
        rvalid_in = 1'b1;
        n = 0;
        quiet = 0;
        while (quiet < 4 && n < 24) begin
            @(posedge clock);
            #1;
            n++;
            if (rdone) begin
                check_value("rdone_cycle", 2 + beat_q.size(), n);
                beat_q.push_back(rdata);
            end else if (beat_q.size() == beats_expected) begin
                quiet++;
            end
            // second start while busy is dropped
            rvalid_in = poke && (n == 2);
        end
        check_value("rdone_count", beats_expected, beat_q.size());
    endtask

    task automatic report_line(input string name, input int c0, input int e0);
        $display("%s: %0d checks, %0d errors", name, check_count - c0, error_count - e0);
    endtask

    // --------------------
    // tests
    // --------------------

    task automatic word_store_load();
        int          c0;
        int          e0;
        logic [31:0] data;
        c0 = check_count;
        e0 = error_count;
        for (int i = 0; i < model_words; i++) begin
            data = rand_word();
            issue_write(sram_addr(i, 0), data, MASK_WORD);
            update_model(i, 2'd0, data, MASK_WORD);
            issue_read(sram_addr(i, 0), MASK_WORD, 1'b0, 8'd0, 1'b0);
            match_beat(0, model_mem[i]);
        end
        report_line("1 word store/load", c0, e0);
    endtask

    task automatic narrow_stores();
        int          c0;
        int          e0;
        int          idx;
        logic [31:0] data;
        lsu_size_e   m;
        c0 = check_count;
        e0 = error_count;
        for (int k = 0; k < 4; k++) begin
            data = rand_word();
            idx = {26'd0, data[5:0]};
            for (int off = 0; off < 4; off++) begin
                for (int j = 0; j < 2; j++) begin
                    if (j == 0) m = MASK_BYTE;
                    else m = MASK_HALF;
                    data = rand_word();
                    issue_write(sram_addr(idx, off), data, m);
                    update_model(idx, 2'(off), data, m);
                    issue_read(sram_addr(idx, 0), MASK_WORD, 1'b0, 8'd0, 1'b0);
                    match_beat(0, model_mem[idx]);
                end
            end
        end
        report_line("2 narrow stores", c0, e0);
    endtask

    task automatic narrow_loads();
        int          c0;
        int          e0;
        int          idx;
        logic [31:0] r;
        lsu_size_e   m;
        c0 = check_count;
        e0 = error_count;
        for (int k = 0; k < 2; k++) begin
            r = rand_word();
            idx = {26'd0, r[5:0]};
            for (int off = 0; off < 4; off++) begin
                for (int j = 0; j < 4; j++) begin
                    if (j < 2) m = MASK_BYTE;
                    else m = MASK_HALF;
                    issue_read(sram_addr(idx, off), m, j[0], 8'd0, 1'b0);
                    match_beat(0, extend_lane(model_mem[idx], 2'(off), m, j[0]));
                end
            end
        end
        report_line("3 narrow loads", c0, e0);
    endtask

    task automatic word_bursts(input int count, input logic poke, input string name);
        int          c0;
        int          e0;
        int          idx;
        logic [31:0] r;
        logic [7:0]  len;
        c0 = check_count;
        e0 = error_count;
        for (int b = 0; b < count; b++) begin
            r = rand_word();
            len = {5'd0, r[2:0]};
            idx = {26'd0, r[10:5]} % (model_words - 8);
            issue_read(sram_addr(idx, 0), MASK_WORD, 1'b0, len, poke);
            for (int k = 0; k <= {24'd0, len}; k++) match_beat(k, model_mem[idx + k]);
        end
        report_line(name, c0, e0);
    endtask

    task automatic clint_reads();
        int          c0;
        int          e0;
        logic [31:0] first_low, second_low;
        c0 = check_count;
        e0 = error_count;
        issue_read(CLINT_BASE, MASK_WORD, 1'b0, 8'd0, 1'b0);
        first_low = (beat_q.size() > 0) ? beat_q[0] : 32'd0;
        issue_read(CLINT_BASE, MASK_WORD, 1'b0, 8'd0, 1'b0);
        second_low = (beat_q.size() > 0) ? beat_q[0] : 32'd0;
        confirm(second_low > first_low, "clint low word did not increase between two loads");
        issue_read(CLINT_BASE + 32'd4, MASK_WORD, 1'b0, 8'd0, 1'b0);
        match_beat(0, 32'd0);
        report_line("5 clint timer", c0, e0);
    endtask

    initial begin
        seed = 20640;
        check_count = 0;
        error_count = 0;
        reset = 1'b1;
        rvalid_in = 1'b0;
        raddr = 32'd0;
        rlen = 8'd0;
        burst = 1'b0;
        rsign = 1'b0;
        rmask = 2'd0;
        wvalid_in = 1'b0;
        waddr = 32'd0;
        wdata = 32'd0;
        wmask = 2'd0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        word_store_load();
        narrow_stores();
        narrow_loads();
        word_bursts(16, 1'b0, "4 word bursts");
        clint_reads();
        word_bursts(4, 1'b1, "6 ignored start");

        check_value("checker_failures", 32'd0, uut.u_master.u_checker.fail_count);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/lsu_pkg.sv
verilog/lsu_store_align.sv
verilog/lsu_bus_master.sv
verilog/lsu_load_extend.sv
verilog/lsu_sram.sv
verilog/lsu_clint.sv
verilog/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb -f filelist.f -o lsu_sim \
    || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/lsu_sim)"
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
